/* hdl/mtap_pkg.sv */
/*
  Shared widths, types and opcodes for the mTAP and its WTAP network.
  Built at one configuration: 4 WTAPs, 2 child TAPs, 4-bit IR.
  TAP select vectors carry a select and an enable bit per child TAP.
  Any opcode not listed here decodes as BYPASS.
*/
package mtap_pkg;

   // --------------------------------------------------
   // Sizes
   // --------------------------------------------------
   localparam int num_wtaps = 4;
   localparam int num_taps  = 2;
   localparam int ir_width  = 4;

   typedef logic [num_wtaps-1:0]  wtap_vec_t;
   typedef logic [2*num_taps-1:0] tap_sel_t;
   typedef logic [ir_width-1:0]   ir_t;
   typedef logic [31:0]           idcode_t;

   // Bit 0 set as required by 1149.1
   localparam idcode_t idcode_value = 32'h0B6D_4013;

   // Opcodes
   localparam ir_t op_idcode  = 4'h2;
   localparam ir_t op_wtapsel = 4'h5;
   localparam ir_t op_tapsel  = 4'h6;
   localparam ir_t op_wtapwir = 4'h9;
   localparam ir_t op_bypass  = 4'hF;

   // --------------------------------------------------
   // TAP controller states
   // --------------------------------------------------
   typedef enum logic [3:0] {
      s_tlr      = 4'h0,
      s_rti      = 4'h1,
      s_sel_dr   = 4'h2,
      s_cap_dr   = 4'h3,
      s_shift_dr = 4'h4,
      s_exit1_dr = 4'h5,
      s_pause_dr = 4'h6,
      s_exit2_dr = 4'h7,
      s_upd_dr   = 4'h8,
      s_sel_ir   = 4'h9,
      s_cap_ir   = 4'hA,
      s_shift_ir = 4'hB,
      s_exit1_ir = 4'hC,
      s_pause_ir = 4'hD,
      s_exit2_ir = 4'hE,
      s_upd_ir   = 4'hF
   } tap_state_t;

   // Per-state strobes from the controller
   typedef struct packed {
      logic capture_ir;
      logic shift_ir;
      logic update_ir;
      logic capture_dr;
      logic shift_dr;
      logic update_dr;
      logic tlr;
   } tap_ctl_t;

   // Decoded instruction, data register selects are one-hot
   typedef struct packed {
      logic sel_bypass;
      logic sel_idcode;
      logic sel_wtapsel;
      logic sel_tapsel;
      logic wtapwir;
   } dr_sel_t;

endpackage

/* hdl/mtap_fsm.sv */
/*
  IEEE 1149.1 TAP controller, 16 states, advanced on rising tck.
  rst_n is synchronous and lands in Test-Logic-Reset, as do five tms ones.
  Strobes are decoded from the current state, so they act on the edge
  that leaves the state.
*/
module mtap_fsm
   import mtap_pkg::*;
(
   input  logic     tck,
   input  logic     rst_n,
   input  logic     tms,
   output tap_ctl_t ctl,
   output logic     shift_any
);

   tap_state_t state;
   tap_state_t state_nxt;

   // --------------------------------------------------
   // Next state from tms
   // --------------------------------------------------
   always_comb
   begin
      case (state)
         s_tlr      : state_nxt = tms ? s_tlr      : s_rti;
         s_rti      : state_nxt = tms ? s_sel_dr   : s_rti;
         s_sel_dr   : state_nxt = tms ? s_sel_ir   : s_cap_dr;
         s_cap_dr   : state_nxt = tms ? s_exit1_dr : s_shift_dr;
         s_shift_dr : state_nxt = tms ? s_exit1_dr : s_shift_dr;
         s_exit1_dr : state_nxt = tms ? s_upd_dr   : s_pause_dr;
         s_pause_dr : state_nxt = tms ? s_exit2_dr : s_pause_dr;
         s_exit2_dr : state_nxt = tms ? s_upd_dr   : s_shift_dr;
         s_upd_dr   : state_nxt = tms ? s_sel_dr   : s_rti;
         s_sel_ir   : state_nxt = tms ? s_tlr      : s_cap_ir;
         s_cap_ir   : state_nxt = tms ? s_exit1_ir : s_shift_ir;
         s_shift_ir : state_nxt = tms ? s_exit1_ir : s_shift_ir;
         s_exit1_ir : state_nxt = tms ? s_upd_ir   : s_pause_ir;
         s_pause_ir : state_nxt = tms ? s_exit2_ir : s_pause_ir;
         s_exit2_ir : state_nxt = tms ? s_upd_ir   : s_shift_ir;
         s_upd_ir   : state_nxt = tms ? s_sel_dr   : s_rti;
         default    : state_nxt = s_tlr;
      endcase
   end

   always_ff @(posedge tck)
   begin
      if (!rst_n)
      begin
         state <= s_tlr;
      end
      else
      begin
         state <= state_nxt;
      end
   end

   // --------------------------------------------------
   // State decode into strobes
   // --------------------------------------------------
   assign ctl.capture_ir = (state == s_cap_ir);
   assign ctl.shift_ir   = (state == s_shift_ir);
   assign ctl.update_ir  = (state == s_upd_ir);
   assign ctl.capture_dr = (state == s_cap_dr);
   assign ctl.shift_dr   = (state == s_shift_dr);
   assign ctl.update_dr  = (state == s_upd_dr);
   assign ctl.tlr        = (state == s_tlr);

   // Drives tdo_en one half cycle later
   assign shift_any = ctl.shift_ir | ctl.shift_dr;

   // At most one register operation per state
   a_ctl_onehot: assert property (@(posedge tck) disable iff (!rst_n)
      $onehot0({ctl.capture_ir, ctl.shift_ir, ctl.update_ir,
                ctl.capture_dr, ctl.shift_dr, ctl.update_dr}));

   // Five tms ones always reach Test-Logic-Reset
   a_five_ones: assert property (@(posedge tck) disable iff (!rst_n)
      tms [*5] |=> ctl.tlr);

endmodule

/* hdl/mtap_ir.sv */
/*
  4-bit instruction register with shift and update stages.
  Capture loads 0001, the active instruction resets to IDCODE.
  Unknown opcodes decode as BYPASS; WTAPWIR also routes through bypass.
*/
module mtap_ir
   import mtap_pkg::*;
(
   input  logic     tck,
   input  logic     rst_n,
   input  logic     tdi,
   input  tap_ctl_t ctl,
   output logic     ir_out,
   output dr_sel_t  dsel,
   output logic     selectwir
);

   ir_t ir_shift;
   ir_t ir_active;

   // --------------------------------------------------
   // Shift stage
   // --------------------------------------------------
   always_ff @(posedge tck)
   begin
      if (ctl.capture_ir)
      begin
         ir_shift <= 4'b0001;
      end
      else if (ctl.shift_ir)
      begin
         // LSB leaves first toward tdo
         ir_shift <= {tdi, ir_shift[ir_width-1:1]};
      end
   end

   assign ir_out = ir_shift[0];

   // Update stage, cleared by rst_n or Test-Logic-Reset
   always_ff @(posedge tck)
   begin
      if (!rst_n || ctl.tlr)
      begin
         ir_active <= op_idcode;
      end
      else if (ctl.update_ir)
      begin
         ir_active <= ir_shift;
      end
   end

   // --------------------------------------------------
   // Opcode decode
   // --------------------------------------------------
   always_comb
   begin
      dsel = '0;
      case (ir_active)
         op_idcode  : dsel.sel_idcode  = 1'b1;
         op_wtapsel : dsel.sel_wtapsel = 1'b1;
         op_tapsel  : dsel.sel_tapsel  = 1'b1;
         op_wtapwir :
         begin
            // WTAP WIR path, mTAP side is bypass
            dsel.sel_bypass = 1'b1;
            dsel.wtapwir    = 1'b1;
         end
         default    : dsel.sel_bypass  = 1'b1;
      endcase
   end

   assign selectwir = dsel.wtapwir;

   // Exactly one data register behind every instruction
   a_dsel_onehot: assert property (@(posedge tck) disable iff (!rst_n)
      $onehot({dsel.sel_bypass, dsel.sel_idcode, dsel.sel_wtapsel, dsel.sel_tapsel}));

endmodule

/* hdl/mtap_dr.sv */
/*
  mTAP data registers: bypass, idcode and the WTAP and TAP selects.
  Select registers have shift and update stages; capture reloads the
  update value. Update values clear in Test-Logic-Reset.
  mux_tdo carries the IR bit during Shift-IR.
*/
module mtap_dr
   import mtap_pkg::*;
(
   input  logic      tck,
   input  logic      rst_n,
   input  logic      tdi,
   input  tap_ctl_t  ctl,
   input  dr_sel_t   dsel,
   input  logic      ir_out,
   output logic      mux_tdo,
   output wtap_vec_t wtap_sel,
   output tap_sel_t  tap_select,
   output logic      wtap_chain
);

   logic      bypass_q;
   idcode_t   idcode_sr;
   wtap_vec_t wtap_sel_sr;
   tap_sel_t  tap_sel_sr;

   // --------------------------------------------------
   // Shift stages
   // --------------------------------------------------
   always_ff @(posedge tck)
   begin
      // Bypass captures 0
      if (ctl.capture_dr && dsel.sel_bypass)
         bypass_q <= 1'b0;
      else if (ctl.shift_dr && dsel.sel_bypass)
         bypass_q <= tdi;

      if (ctl.capture_dr && dsel.sel_idcode)
         idcode_sr <= idcode_value;
      else if (ctl.shift_dr && dsel.sel_idcode)
         idcode_sr <= {tdi, idcode_sr[31:1]};

      // Select shifters read back the live value
      if (ctl.capture_dr && dsel.sel_wtapsel)
         wtap_sel_sr <= wtap_sel;
      else if (ctl.shift_dr && dsel.sel_wtapsel)
         wtap_sel_sr <= {tdi, wtap_sel_sr[num_wtaps-1:1]};

      if (ctl.capture_dr && dsel.sel_tapsel)
         tap_sel_sr <= tap_select;
      else if (ctl.shift_dr && dsel.sel_tapsel)
         tap_sel_sr <= {tdi, tap_sel_sr[2*num_taps-1:1]};
   end

   // Update stages
   always_ff @(posedge tck)
   begin
      if (!rst_n || ctl.tlr)
      begin
         wtap_sel   <= '0;
         tap_select <= '0;
      end
      else if (ctl.update_dr)
      begin
         if (dsel.sel_wtapsel)
            wtap_sel <= wtap_sel_sr;
         if (dsel.sel_tapsel)
            tap_select <= tap_sel_sr;
      end
   end

   // --------------------------------------------------
   // Serial output mux
   // --------------------------------------------------
   always_comb
   begin
      if (ctl.shift_ir)
         mux_tdo = ir_out;
      else if (dsel.sel_idcode)
         mux_tdo = idcode_sr[0];
      else if (dsel.sel_wtapsel)
         mux_tdo = wtap_sel_sr[0];
      else if (dsel.sel_tapsel)
         mux_tdo = tap_sel_sr[0];
      else
         mux_tdo = bypass_q;
   end

   // WTAPs join the chain unless a select register is being accessed
   assign wtap_chain = (|wtap_sel) && !dsel.sel_wtapsel && !dsel.sel_tapsel;

endmodule

/* hdl/mtap_wtapnw.sv */
/*
  WTAP network steering, purely combinational.
  Only the highest selected WTAP sees the mTAP serial data; others see 1.
  Any child TAP select or override bit parks every wsi at 1.
*/
module mtap_wtapnw
   import mtap_pkg::*;
(
   input  logic      mtap_mux_tdo,
   input  logic      mtap_selectwir,
   input  wtap_vec_t cn_awtap_wso,
   input  wtap_vec_t cltapc_wtap_sel,
   input  tap_sel_t  cltapc_select,
   input  tap_sel_t  cltapc_select_ovr,
   output logic      cn_fwtap_selectwir,
   output wtap_vec_t cn_fwtap_wsi,
   output logic      mtap_wtapnw_tdo
);

   wtap_vec_t top_sel;
   logic      wsi_park;

   // --------------------------------------------------
   // Highest selected WTAP as a one-hot
   // --------------------------------------------------
   always_comb
   begin
      top_sel = '0;
      // Later hits override earlier ones
      for (int i = 0; i < num_wtaps; i++)
      begin
         if (cltapc_wtap_sel[i])
            top_sel = wtap_vec_t'(1) << i;
      end
   end

   // Nothing selected, or a child TAP owns the chain
   assign wsi_park = (~|cltapc_wtap_sel) | (|(cltapc_select | cltapc_select_ovr));

   always_comb
   begin
      for (int i = 0; i < num_wtaps; i++)
      begin
         if (!wsi_park && top_sel[i])
            cn_fwtap_wsi[i] = mtap_mux_tdo;
         else
            cn_fwtap_wsi[i] = 1'b1;
      end
   end

   // Network tdo from the same WTAP, 0 when none selected
   assign mtap_wtapnw_tdo = |(top_sel & cn_awtap_wso);

   assign cn_fwtap_selectwir = mtap_selectwir;

endmodule

/* hdl/mtap_tdo.sv */
/*
  Falling-edge tdo stage.
  tdo idles at 1 outside Shift-IR and Shift-DR; tdo_en follows the shift.
*/
module mtap_tdo
(
   input  logic tck,
   input  logic rst_n,
   input  logic shift_any,
   input  logic wtap_chain,
   input  logic mux_tdo,
   input  logic wtapnw_tdo,
   output logic tdo,
   output logic tdo_en
);

   // Retimed half a cycle after the source changes
   always_ff @(negedge tck)
   begin
      if (!rst_n)
      begin
         tdo    <= 1'b1;
         tdo_en <= 1'b0;
      end
      else
      begin
         tdo_en <= shift_any;
         if (!shift_any)
            tdo <= 1'b1;
         else if (wtap_chain)
            tdo <= wtapnw_tdo;
         else
            tdo <= mux_tdo;
      end
   end

endmodule

/* hdl/mtap_top.sv */
/*
  mTAP top: controller, IR, data registers, WTAP network and tdo stage.
  WTAPs and child TAPs sit outside; wso returns from them on the wso port.
*/
module mtap_top
   import mtap_pkg::*;
(
   input  logic      tck,
   input  logic      rst_n,
   input  logic      tms,
   input  logic      tdi,
   input  tap_sel_t  tap_select_ovr,
   input  wtap_vec_t wso,
   output logic      tdo,
   output logic      tdo_en,
   output wtap_vec_t wsi,
   output logic      fwtap_selectwir
);

   tap_ctl_t  ctl;
   dr_sel_t   dsel;
   logic      shift_any;
   logic      ir_out;
   logic      selectwir;
   logic      mux_tdo;
   logic      wtap_chain;
   logic      wtapnw_tdo;
   wtap_vec_t wtap_sel;
   tap_sel_t  tap_select;

   // --------------------------------------------------
   // Decode
   // --------------------------------------------------
   mtap_fsm u_fsm (
      .tck       (tck),
      .rst_n     (rst_n),
      .tms       (tms),
      .ctl       (ctl),
      .shift_any (shift_any)
   );

   mtap_ir u_ir (
      .tck       (tck),
      .rst_n     (rst_n),
      .tdi       (tdi),
      .ctl       (ctl),
      .ir_out    (ir_out),
      .dsel      (dsel),
      .selectwir (selectwir)
   );

   // Execute
   mtap_dr u_dr (
      .tck        (tck),
      .rst_n      (rst_n),
      .tdi        (tdi),
      .ctl        (ctl),
      .dsel       (dsel),
      .ir_out     (ir_out),
      .mux_tdo    (mux_tdo),
      .wtap_sel   (wtap_sel),
      .tap_select (tap_select),
      .wtap_chain (wtap_chain)
   );

   mtap_wtapnw u_wtapnw (
      .mtap_mux_tdo       (mux_tdo),
      .mtap_selectwir     (selectwir),
      .cn_awtap_wso       (wso),
      .cltapc_wtap_sel    (wtap_sel),
      .cltapc_select      (tap_select),
      .cltapc_select_ovr  (tap_select_ovr),
      .cn_fwtap_selectwir (fwtap_selectwir),
      .cn_fwtap_wsi       (wsi),
      .mtap_wtapnw_tdo    (wtapnw_tdo)
   );

   // Result
   mtap_tdo u_tdo (
      .tck        (tck),
      .rst_n      (rst_n),
      .shift_any  (shift_any),
      .wtap_chain (wtap_chain),
      .mux_tdo    (mux_tdo),
      .wtapnw_tdo (wtapnw_tdo),
      .tdo        (tdo),
      .tdo_en     (tdo_en)
   );

endmodule

/* verif/mtap_tb.sv */
/*
  Testbench for the mTAP with a four-WTAP loop model.
  Each WTAP is one flop from wsi back to wso.
  JTAG tasks start and end in Run-Test/Idle, 10 units after a rising edge.
  wsi and selectwir are checked on falling tck, tdo and tdo_en on rising tck.
*/
module mtap_tb
   import mtap_pkg::*;
;

   // Tests take about 600 cycles, limit leaves a wide margin
   localparam int max_cycles = 4000;

   logic        tck;
   logic        rst_n;
   logic        tms;
   logic        tdi;
   tap_sel_t    tap_select_ovr;
   wtap_vec_t   wso = '1;
   logic        tdo;
   logic        tdo_en;
   wtap_vec_t   wsi;
   logic        fwtap_selectwir;

   // Values the testbench itself wrote into the DUT
   wtap_vec_t   exp_wsel;
   tap_sel_t    exp_tsel;
   logic        exp_wir;
   logic        shifting;
   wtap_vec_t   top_mask;
   logic        park_exp;

   integer      seed;
   int          errors;
   int          err_mark;
   int          tests_done;
   int          cycles = 0;
   logic [31:0] rnd;
   logic [31:0] got;
   wtap_vec_t   sel;
   logic        b;

   mtap_top UUT (
      .tck             (tck),
      .rst_n           (rst_n),
      .tms             (tms),
      .tdi             (tdi),
      .tap_select_ovr  (tap_select_ovr),
      .wso             (wso),
      .tdo             (tdo),
      .tdo_en          (tdo_en),
      .wsi             (wsi),
      .fwtap_selectwir (fwtap_selectwir)
   );

   initial
   begin
      tck = 1'b0;
      forever #50 tck = ~tck;
   end

   // WTAP model, wsi returns on wso one cycle later
   always @(posedge tck)
      wso <= wsi;

   always @(posedge tck)
   begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles)
      begin
         $display("Run stopped, no end after %0d cycles", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   // --------------------------------------------------
   // Expected network state
   // --------------------------------------------------
   function automatic wtap_vec_t top_wtap_mask(input wtap_vec_t v);
      wtap_vec_t m;
      m = '0;
      for (int i = 0; i < num_wtaps; i++)
      begin
         if (v[i])
            m = '0;
         if (v[i])
            m[i] = 1'b1;
      end
      return m;
   endfunction

   assign top_mask = top_wtap_mask(exp_wsel);
   // No WTAP, or a child TAP owns the chain
   assign park_exp = (exp_wsel == '0) || (|(exp_tsel | tap_select_ovr));

   a_wsi: assert property (@(negedge tck) disable iff (!rst_n)
      park_exp ? (wsi == '1) : ((wsi | top_mask) == '1))
   else
   begin
      $display("wsi not parked or steered as selected at cycle %0d", cycles);
      errors++;
   end

   a_selectwir: assert property (@(negedge tck) disable iff (!rst_n)
      fwtap_selectwir == exp_wir)
   else
   begin
      $display("fwtap_selectwir does not follow WTAPWIR at cycle %0d", cycles);
      errors++;
   end

   // tdo_en only in Shift-xR, tdo idles high
   a_tdo_en: assert property (@(posedge tck) disable iff (!rst_n)
      shifting ? tdo_en : (!tdo_en && tdo))
   else
   begin
      $display("tdo_en or idle tdo wrong at cycle %0d", cycles);
      errors++;
   end

   // --------------------------------------------------
   // JTAG tasks
   // --------------------------------------------------
   task automatic step(input logic tms_v, input logic tdi_v, input logic shf,
                       output logic tdo_s);
      tms      = tms_v;
      tdi      = tdi_v;
      shifting = shf;
      @(posedge tck);
      tdo_s = tdo;
      #10;
   endtask

   task automatic idle(input int n);
      logic t;
      repeat (n) step(1'b0, 1'b0, 1'b0, t);
   endtask

   // Starts in Run-Test/Idle, TLR is first active on the fourth edge
   task automatic goto_reset;
      logic t;
      for (int i = 0; i < 5; i++)
      begin
         step(1'b1, 1'b0, 1'b0, t);
         if (i == 3)
         begin
            exp_wsel = '0;
            exp_tsel = '0;
            exp_wir  = 1'b0;
         end
      end
      step(1'b0, 1'b0, 1'b0, t);
   endtask

   task automatic shift_ir(input ir_t code);
      logic t;
      step(1'b1, 1'b0, 1'b0, t);
      step(1'b1, 1'b0, 1'b0, t);
      step(1'b0, 1'b0, 1'b0, t);
      step(1'b0, 1'b0, 1'b0, t);
      for (int i = 0; i < ir_width; i++)
         step(i == ir_width - 1, code[i], 1'b1, t);
      step(1'b1, 1'b0, 1'b0, t);
      // New instruction active from the edge leaving Update-IR
      step(1'b0, 1'b0, 1'b0, t);
      exp_wir = (code == op_wtapwir);
   endtask

   // LSB first; dout[i] is tdo at the rising edge that shifts din[i]
   task automatic shift_dr(input int n, input logic [31:0] din, output logic [31:0] dout);
      logic t;
      dout = '0;
      step(1'b1, 1'b0, 1'b0, t);
      step(1'b0, 1'b0, 1'b0, t);
      step(1'b0, 1'b0, 1'b0, t);
      for (int i = 0; i < n; i++)
      begin
         step(i == n - 1, din[i], 1'b1, t);
         dout[i] = t;
      end
      step(1'b1, 1'b0, 1'b0, t);
      step(1'b0, 1'b0, 1'b0, t);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (exp === act)
      else
      begin
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   // Capture reloads the live select, so the old value reads back
   task automatic write_wtap_sel(input wtap_vec_t v);
      logic [31:0] q;
      shift_ir(op_wtapsel);
      shift_dr(num_wtaps, 32'(v), q);
      check_value("wtap_sel_readback", 32'(exp_wsel), 32'(q[num_wtaps-1:0]));
      exp_wsel = v;
   endtask

   task automatic write_tap_sel(input tap_sel_t v);
      logic [31:0] q;
      shift_ir(op_tapsel);
      shift_dr(2*num_taps, 32'(v), q);
      check_value("tap_sel_readback", 32'(exp_tsel), 32'(q[2*num_taps-1:0]));
      exp_tsel = v;
   endtask

   task automatic end_test(input string name);
      $display("%-20s done, %0d error(s)", name, errors - err_mark);
      err_mark = errors;
      tests_done++;
   endtask

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------
   initial
   begin
      seed           = 32'h71d3205e;
      errors         = 0;
      err_mark       = 0;
      tests_done     = 0;
      rst_n          = 1'b0;
      tms            = 1'b1;
      tdi            = 1'b0;
      tap_select_ovr = '0;
      shifting       = 1'b0;
      exp_wsel       = '0;
      exp_tsel       = '0;
      exp_wir        = 1'b0;
      repeat (8) @(posedge tck);
      #10;
      rst_n = 1'b1;
      step(1'b0, 1'b0, 1'b0, b);

      // IDCODE is the reset instruction
      shift_dr(32, 32'h0, got);
      check_value("idcode_after_reset", idcode_value, got);
      end_test("idcode_after_reset");

      // One-bit bypass, then an unused opcode
      shift_ir(op_bypass);
      repeat (4)
      begin
         rnd = $random(seed);
         shift_dr(16, rnd, got);
         check_value("bypass", 32'({rnd[14:0], 1'b0}), 32'(got[15:0]));
      end
      shift_ir(4'hA);
      rnd = $random(seed);
      shift_dr(16, rnd, got);
      check_value("bypass_unused_op", 32'({rnd[14:0], 1'b0}), 32'(got[15:0]));
      end_test("bypass");

      // Bypass plus the looped WTAP adds a second bit of delay
      repeat (2)
      begin
         rnd = $random(seed);
         sel = rnd[num_wtaps-1:0];
         if (sel == '0)
            sel = 4'b0100;
         write_wtap_sel(sel);
         write_wtap_sel(sel);
         shift_ir(op_bypass);
         repeat (3)
         begin
            rnd = $random(seed);
            shift_dr(16, rnd, got);
            // got[0] is the stale WTAP bit, not checked
            check_value("wtap_loop", 32'({rnd[13:0], 1'b0}), 32'(got[15:1]));
         end
      end
      end_test("wtap_loop");

      // Override, TAP select and empty select all park wsi
      rnd = $random(seed);
      tap_select_ovr = rnd[2*num_taps-1:0] | 4'b0001;
      // Zeros on the bypass path would reach the top wsi unless parked
      shift_dr(16, 32'h0, got);
      tap_select_ovr = '0;
      idle(2);
      rnd = $random(seed);
      write_tap_sel(rnd[2*num_taps-1:0] | 4'b0010);
      idle(3);
      write_tap_sel('0);
      idle(2);
      write_wtap_sel('0);
      idle(2);
      end_test("wsi_park");

      shift_ir(op_wtapwir);
      idle(2);
      check_value("selectwir_on", 32'd1, 32'(fwtap_selectwir));
      shift_ir(op_bypass);
      idle(2);
      check_value("selectwir_off", 32'd0, 32'(fwtap_selectwir));
      end_test("selectwir");

      // Five tms ones clear the selects and restore IDCODE
      write_wtap_sel(4'b1010);
      write_tap_sel(4'b0101);
      goto_reset();
      shift_dr(32, 32'h0, got);
      check_value("idcode_after_tlr", idcode_value, got);
      write_wtap_sel('0);
      write_tap_sel('0);
      end_test("tms_reset");

      $display("%0d tests run, %0d errors, %0d cycles", tests_done, errors, cycles);
      if (errors == 0)
      begin
         $display("TEST PASSED");
      end
      else
      begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* sim.f */
hdl/mtap_pkg.sv
hdl/mtap_fsm.sv
hdl/mtap_ir.sv
hdl/mtap_dr.sv
hdl/mtap_wtapnw.sv
hdl/mtap_tdo.sv
hdl/mtap_top.sv
verif/mtap_tb.sv

/* Makefile */
# Verilator build and run for the mTAP testbench
# Override any variable on the command line, e.g. make run LOG=run.log

VERILATOR ?= verilator
TOP       ?= mtap_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
